// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipe_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_core;

    localparam int PROG_LEN    = 32;
    localparam int STORE_COUNT = 10;
    localparam int CYCLE_LIMIT = 20 * PROG_LEN;

    logic        clk;
    logic        rst_n;
    logic [31:0] iad;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] dad;
    logic [31:0] ddt_w;
    logic [31:0] ddt_r;
    logic        mreq;
    logic        write;
    logic [1:0]  size;
    logic        ackd_n;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:127];
    logic [31:0] prog [0:PROG_LEN-1];
    logic [31:0] exp_addr [0:STORE_COUNT-1];
    logic [31:0] exp_data [0:STORE_COUNT-1];

    integer seed;
    int     errors;
    int     stores_seen;
    int     cycles;
    int     idelay;
    int     ddelay;

    pipe_core i_pipe_core (
        .clk      (clk),
        .i_rst_n  (rst_n),
        .o_iad    (iad),
        .i_idt    (idt),
        .i_acki_n (acki_n),
        .o_dad    (dad),
        .o_ddt_w  (ddt_w),
        .i_ddt_r  (ddt_r),
        .o_mreq   (mreq),
        .o_write  (write),
        .o_size   (size),
        .i_ackd_n (ackd_n)
    );

    function automatic logic [31:0] reg_reg(input logic [6:0] f7, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] reg_imm(input logic [6:0] opc, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                               input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_cond(input logic [2:0] f3, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic record_store(input logic [31:0] addr, input logic [31:0] data);
        if (stores_seen < STORE_COUNT) begin
            check_value($sformatf("store %0d address", stores_seen), addr, exp_addr[stores_seen]);
            check_value($sformatf("store %0d data", stores_seen), data, exp_data[stores_seen]);
        end else begin
            $display("Unexpected extra store to %h at %0t ns", addr, $time);
            errors++;
        end
        stores_seen++;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycles <= cycles + 1;
        end
    end

    // Acks go low only after a high cycle, when the request is known to be frozen
    always @(posedge clk) begin
        if (!rst_n) begin
            acki_n <= 1'b1;
            ackd_n <= 1'b1;
        end else begin
            if (!acki_n) begin
                acki_n <= 1'b1;
            end else if (idelay > 0) begin
                idelay <= idelay - 1;
            end else begin
                idt    <= imem[iad[7:2]];
                acki_n <= 1'b0;
                idelay <= {$random(seed)} % 3;
            end

            if (mreq && !ackd_n) begin
                // RISC-V word size code
                check_value("access size", {30'd0, size}, 32'd2);
                if (write) begin
                    dmem[dad[8:2]] <= ddt_w;
                    record_store(dad, ddt_w);
                end
                ackd_n <= 1'b1;
            end else if (!ackd_n) begin
                ackd_n <= 1'b1;
            end else if (mreq) begin
                if (ddelay > 0) begin
                    ddelay <= ddelay - 1;
                end else begin
                    ddt_r  <= dmem[dad[8:2]];
                    ackd_n <= 1'b0;
                    ddelay <= {$random(seed)} % 3;
                end
            end
        end
    end

    initial begin
        seed        = 32'h922e_00d6;
        errors      = 0;
        stores_seen = 0;
        cycles      <= 0;
        idelay      <= 0;
        ddelay      <= 0;
        rst_n       <= 1'b0;
        acki_n      <= 1'b1;
        ackd_n      <= 1'b1;
        idt         <= 32'h0000_0013;
        ddt_r       <= 32'd0;

        for (int i = 0; i < 128; i++) begin
            dmem[i] <= 32'h1000_0000 + i * 32'h0004_0404;
        end

        // Forwarding chain
        prog[0]  = reg_imm(7'b0010011, 3'b000, 5'd1, 5'd0, 95);
        prog[1]  = reg_imm(7'b0010011, 3'b000, 5'd2, 5'd1, -2);
        prog[2]  = reg_reg(7'b0000000, 3'b000, 5'd3, 5'd1, 5'd2);
        prog[3]  = reg_reg(7'b0100000, 3'b000, 5'd4, 5'd2, 5'd3);
        prog[4]  = reg_reg(7'b0000000, 3'b111, 5'd5, 5'd4, 5'd3);
        prog[5]  = reg_reg(7'b0000000, 3'b110, 5'd6, 5'd5, 5'd1);
        prog[6]  = reg_reg(7'b0000000, 3'b010, 5'd7, 5'd4, 5'd1);
        prog[7]  = reg_reg(7'b0000000, 3'b010, 5'd8, 5'd1, 5'd4);
        prog[8]  = store_word(5'd8, 5'd0, 32'h94);
        prog[9]  = store_word(5'd7, 5'd0, 32'h90);
        prog[10] = store_word(5'd3, 5'd0, 32'h80);
        prog[11] = store_word(5'd4, 5'd0, 32'h84);
        prog[12] = store_word(5'd5, 5'd0, 32'h88);
        prog[13] = store_word(5'd6, 5'd0, 32'h8c);
        // Load-use
        prog[14] = reg_imm(7'b0000011, 3'b010, 5'd9, 5'd0, 32'h40);
        prog[15] = reg_reg(7'b0000000, 3'b000, 5'd10, 5'd9, 5'd1);
        prog[16] = store_word(5'd10, 5'd0, 32'h98);
        // Taken branches then not taken ones
        prog[17] = branch_cond(3'b000, 5'd1, 5'd1, 12);
        prog[18] = store_word(5'd1, 5'd0, 32'ha0);
        prog[19] = store_word(5'd2, 5'd0, 32'ha4);
        prog[20] = branch_cond(3'b001, 5'd1, 5'd2, 12);
        prog[21] = store_word(5'd1, 5'd0, 32'ha8);
        prog[22] = store_word(5'd2, 5'd0, 32'hac);
        prog[23] = branch_cond(3'b000, 5'd1, 5'd2, 8);
        prog[24] = store_word(5'd1, 5'd0, 32'hb0);
        prog[25] = branch_cond(3'b001, 5'd1, 5'd1, 8);
        prog[26] = store_word(5'd2, 5'd0, 32'hb4);
        // JAL with link and a final spin loop
        prog[27] = jump_link(5'd11, 12);
        prog[28] = store_word(5'd1, 5'd0, 32'hb8);
        prog[29] = store_word(5'd2, 5'd0, 32'hbc);
        prog[30] = store_word(5'd11, 5'd0, 32'hc0);
        prog[31] = jump_link(5'd0, 0);

        exp_addr[0] = 32'h94;
        exp_data[0] = 32'h0000_0000;
        exp_addr[1] = 32'h90;
        exp_data[1] = 32'h0000_0001;
        exp_addr[2] = 32'h80;
        exp_data[2] = 32'h0000_00bc;
        exp_addr[3] = 32'h84;
        exp_data[3] = 32'hffff_ffa1;
        exp_addr[4] = 32'h88;
        exp_data[4] = 32'h0000_00a0;
        exp_addr[5] = 32'h8c;
        exp_data[5] = 32'h0000_00ff;
        exp_addr[6] = 32'h98;
        exp_data[6] = 32'h1040_409f;
        exp_addr[7] = 32'hb0;
        exp_data[7] = 32'h0000_005f;
        exp_addr[8] = 32'hb4;
        exp_data[8] = 32'h0000_005d;
        exp_addr[9] = 32'hc0;
        exp_data[9] = 32'h0000_0070;

        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < PROG_LEN) ? prog[i] : 32'h0000_0013;
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        @(negedge clk);
        check_value("o_iad after reset", iad, 32'd0);
        check_value("o_mreq after reset", {31'd0, mreq}, 32'd0);
        check_value("o_write after reset", {31'd0, write}, 32'd0);

        while (stores_seen < STORE_COUNT && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
        end

        if (stores_seen < STORE_COUNT) begin
            $display("Timeout after %0d cycles, only %0d of %0d stores appeared",
                     cycles, stores_seen, STORE_COUNT);
            errors++;
        end else begin
            // Let the spin loop run to catch stray stores
            repeat (20) @(negedge clk);
        end

        $display("Errors: %0d, stores seen: %0d", errors, stores_seen);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN = 32;

    // RV32I major opcodes handled by the core
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    localparam logic [1:0] SIZE_WORD = 2'b10;

    // addi x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_hold,
    input  wire                       i_stall_id,
    input  wire                       i_flush,
    input  wire [core_pkg::XLEN-1:0]  i_pc,
    input  wire [core_pkg::XLEN-1:0]  i_instr,
    input  wire [core_pkg::XLEN-1:0]  i_rs1_data,
    input  wire [core_pkg::XLEN-1:0]  i_rs2_data,
    output logic [4:0]                o_rs1,
    output logic [4:0]                o_rs2,
    output logic [core_pkg::XLEN-1:0] o_ex_pc,
    output logic [core_pkg::XLEN-1:0] o_ex_a,
    output logic [core_pkg::XLEN-1:0] o_ex_b,
    output logic [core_pkg::XLEN-1:0] o_ex_imm,
    output logic [4:0]                o_ex_rs1,
    output logic [4:0]                o_ex_rs2,
    output logic [4:0]                o_ex_rd,
    output core_pkg::alu_op_e         o_ex_alu_op,
    output logic                      o_ex_use_imm,
    output logic                      o_ex_load,
    output logic                      o_ex_store,
    output logic                      o_ex_branch,
    output logic                      o_ex_bne,
    output logic                      o_ex_jal,
    output logic                      o_ex_wb_en
);

    logic [6:0]                opcode;
    logic [4:0]                rd;
    logic [2:0]                funct3;
    logic [core_pkg::XLEN-1:0] imm_i;
    logic [core_pkg::XLEN-1:0] imm_s;
    logic [core_pkg::XLEN-1:0] imm_b;
    logic [core_pkg::XLEN-1:0] imm_j;
    logic [core_pkg::XLEN-1:0] imm;
    core_pkg::alu_op_e         alu_op;
    logic                      use_imm;
    logic                      is_load;
    logic                      is_store;
    logic                      is_branch;
    logic                      is_jal;
    logic                      wb_en;
    logic                      bubble;

    assign opcode = i_instr[6:0];
    assign rd     = i_instr[11:7];
    assign funct3 = i_instr[14:12];
    assign o_rs1  = i_instr[19:15];
    assign o_rs2  = i_instr[24:20];
    assign bubble = i_stall_id | i_flush;

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    always_comb begin
        alu_op    = core_pkg::ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        is_jal    = 1'b0;
        wb_en     = 1'b0;
        case (opcode)
            core_pkg::OP_REG: begin
                wb_en = 1'b1;
                case (funct3)
                    3'b000: begin
                        if (i_instr[30]) begin
                            alu_op = core_pkg::ALU_SUB;
                        end
                    end
                    3'b010: alu_op = core_pkg::ALU_SLT;
                    3'b110: alu_op = core_pkg::ALU_OR;
                    3'b111: alu_op = core_pkg::ALU_AND;
                    default: alu_op = core_pkg::ALU_ADD;
                endcase
            end
            core_pkg::OP_IMM: begin
                use_imm = 1'b1;
                wb_en   = 1'b1;
            end
            core_pkg::OP_LOAD: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                wb_en   = 1'b1;
            end
            core_pkg::OP_STORE: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
                imm      = imm_s;
            end
            core_pkg::OP_BRANCH: begin
                is_branch = 1'b1;
                imm       = imm_b;
            end
            core_pkg::OP_JAL: begin
                is_jal = 1'b1;
                wb_en  = 1'b1;
                imm    = imm_j;
            end
            default: ;
        endcase
    end

    // A bubble in ID/EX decodes like the NOP encoding
    always_ff @(posedge clk) begin
        if (!i_rst_n || (!i_hold && bubble)) begin
            o_ex_rs1     <= 5'd0;
            o_ex_rs2     <= 5'd0;
            o_ex_rd      <= 5'd0;
            o_ex_alu_op  <= core_pkg::ALU_ADD;
            o_ex_use_imm <= 1'b1;
            o_ex_load    <= 1'b0;
            o_ex_store   <= 1'b0;
            o_ex_branch  <= 1'b0;
            o_ex_bne     <= 1'b0;
            o_ex_jal     <= 1'b0;
            o_ex_wb_en   <= 1'b0;
        end else if (!i_hold) begin
            o_ex_rs1     <= o_rs1;
            o_ex_rs2     <= o_rs2;
            o_ex_rd      <= rd;
            o_ex_alu_op  <= alu_op;
            o_ex_use_imm <= use_imm;
            o_ex_load    <= is_load;
            o_ex_store   <= is_store;
            o_ex_branch  <= is_branch;
            o_ex_bne     <= is_branch & funct3[0];
            o_ex_jal     <= is_jal;
            o_ex_wb_en   <= wb_en && (rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_ex_pc  <= i_pc;
            o_ex_a   <= i_rs1_data;
            o_ex_b   <= i_rs2_data;
            o_ex_imm <= imm;
        end
    end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_hold,
    input  wire [core_pkg::XLEN-1:0]  i_ex_pc,
    input  wire [core_pkg::XLEN-1:0]  i_ex_a,
    input  wire [core_pkg::XLEN-1:0]  i_ex_b,
    input  wire [core_pkg::XLEN-1:0]  i_ex_imm,
    input  wire [4:0]                 i_ex_rd,
    input  wire core_pkg::alu_op_e    i_ex_alu_op,
    input  wire                       i_ex_use_imm,
    input  wire                       i_ex_load,
    input  wire                       i_ex_store,
    input  wire                       i_ex_branch,
    input  wire                       i_ex_bne,
    input  wire                       i_ex_jal,
    input  wire                       i_ex_wb_en,
    input  wire core_pkg::fwd_sel_e   i_fwd_a,
    input  wire core_pkg::fwd_sel_e   i_fwd_b,
    input  wire [core_pkg::XLEN-1:0]  i_mem_result,
    input  wire [core_pkg::XLEN-1:0]  i_wb_data,
    output logic                      o_taken,
    output logic [core_pkg::XLEN-1:0] o_target,
    output logic [core_pkg::XLEN-1:0] o_mem_result,
    output logic [core_pkg::XLEN-1:0] o_mem_store_data,
    output logic [4:0]                o_mem_rd,
    output logic                      o_mem_load,
    output logic                      o_mem_store,
    output logic                      o_mem_wb_en
);

    logic [core_pkg::XLEN-1:0] op_a;
    logic [core_pkg::XLEN-1:0] rs2_val;
    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] alu_y;

    always_comb begin
        case (i_fwd_a)
            core_pkg::FWD_MEM: op_a = i_mem_result;
            core_pkg::FWD_WB:  op_a = i_wb_data;
            default:           op_a = i_ex_a;
        endcase
        case (i_fwd_b)
            core_pkg::FWD_MEM: rs2_val = i_mem_result;
            core_pkg::FWD_WB:  rs2_val = i_wb_data;
            default:           rs2_val = i_ex_b;
        endcase
    end

    assign op_b = i_ex_use_imm ? i_ex_imm : rs2_val;

    always_comb begin
        case (i_ex_alu_op)
            core_pkg::ALU_SUB: alu_y = op_a - op_b;
            core_pkg::ALU_AND: alu_y = op_a & op_b;
            core_pkg::ALU_OR:  alu_y = op_a | op_b;
            core_pkg::ALU_SLT: alu_y = {{(core_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default:           alu_y = op_a + op_b;
        endcase
    end

    // BNE inverts the equality test
    assign o_taken  = i_ex_jal | (i_ex_branch & ((op_a == rs2_val) ^ i_ex_bne));
    assign o_target = i_ex_pc + i_ex_imm;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_mem_rd    <= 5'd0;
            o_mem_load  <= 1'b0;
            o_mem_store <= 1'b0;
            o_mem_wb_en <= 1'b0;
        end else if (!i_hold) begin
            o_mem_rd    <= i_ex_rd;
            o_mem_load  <= i_ex_load;
            o_mem_store <= i_ex_store;
            o_mem_wb_en <= i_ex_wb_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_mem_result     <= i_ex_jal ? (i_ex_pc + 32'd4) : alu_y;
            o_mem_store_data <= rs2_val;
        end
    end

endmodule

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_hold,
    input  wire                       i_stall_id,
    input  wire                       i_flush,
    input  wire [core_pkg::XLEN-1:0]  i_target,
    input  wire [core_pkg::XLEN-1:0]  i_idt,
    output logic [core_pkg::XLEN-1:0] o_iad,
    output logic [core_pkg::XLEN-1:0] o_if_pc,
    output logic [core_pkg::XLEN-1:0] o_if_instr
);

    logic [core_pkg::XLEN-1:0] pc;

    assign o_iad = pc;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc         <= '0;
            o_if_instr <= core_pkg::NOP_INSTR;
        end else if (!i_hold) begin
            if (i_flush) begin
                // Redirect and squash the word fetched down the wrong path
                pc         <= i_target;
                o_if_instr <= core_pkg::NOP_INSTR;
            end else if (!i_stall_id) begin
                pc         <= pc + 32'd4;
                o_if_instr <= i_idt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold && !i_stall_id && !i_flush) begin
            o_if_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
    input  wire                i_acki_n,
    input  wire                i_ackd_n,
    input  wire                i_mreq,
    input  wire [4:0]          i_id_rs1,
    input  wire [4:0]          i_id_rs2,
    input  wire [4:0]          i_ex_rs1,
    input  wire [4:0]          i_ex_rs2,
    input  wire [4:0]          i_ex_rd,
    input  wire                i_ex_load,
    input  wire                i_ex_wb_en,
    input  wire [4:0]          i_mem_rd,
    input  wire                i_mem_wb_en,
    input  wire                i_mem_load,
    input  wire [4:0]          i_wb_rd,
    input  wire                i_wb_en,
    input  wire                i_taken,
    output logic               o_hold,
    output logic               o_stall_id,
    output logic               o_flush,
    output core_pkg::fwd_sel_e o_fwd_a,
    output core_pkg::fwd_sel_e o_fwd_b
);

    logic load_use;

    // Younger producer in EX/MEM wins over MEM/WB
    function automatic core_pkg::fwd_sel_e fwd_for(input logic [4:0] rs);
        core_pkg::fwd_sel_e sel;
        sel = core_pkg::FWD_RF;
        if (rs != 5'd0) begin
            if (i_mem_wb_en && !i_mem_load && (i_mem_rd == rs)) begin
                sel = core_pkg::FWD_MEM;
            end else if (i_wb_en && (i_wb_rd == rs)) begin
                sel = core_pkg::FWD_WB;
            end
        end
        return sel;
    endfunction

    assign o_hold = i_acki_n | (i_mreq & i_ackd_n);

    // wb_en is already low for rd == x0
    assign load_use = i_ex_load & i_ex_wb_en &
                      ((i_ex_rd == i_id_rs1) | (i_ex_rd == i_id_rs2));

    assign o_flush    = i_taken;
    assign o_stall_id = load_use & ~i_taken;

    always_comb begin
        o_fwd_a = fwd_for(i_ex_rs1);
        o_fwd_b = fwd_for(i_ex_rs2);
    end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_hold,
    input  wire [core_pkg::XLEN-1:0]  i_mem_result,
    input  wire [core_pkg::XLEN-1:0]  i_mem_store_data,
    input  wire [4:0]                 i_mem_rd,
    input  wire                       i_mem_load,
    input  wire                       i_mem_store,
    input  wire                       i_mem_wb_en,
    input  wire [core_pkg::XLEN-1:0]  i_ddt_r,
    input  wire                       i_ackd_n,
    output logic [core_pkg::XLEN-1:0] o_dad,
    output logic [core_pkg::XLEN-1:0] o_ddt_w,
    output logic                      o_mreq,
    output logic                      o_write,
    output logic [1:0]                o_size,
    output logic                      o_wb_en,
    output logic [4:0]                o_wb_rd,
    output logic [core_pkg::XLEN-1:0] o_wb_data
);

    logic                      done;
    logic [core_pkg::XLEN-1:0] load_q;
    logic [core_pkg::XLEN-1:0] wb_value;

    // Request drops once acked, even if the instruction bus still freezes us
    assign o_mreq  = (i_mem_load | i_mem_store) & ~done;
    assign o_write = i_mem_store & ~done;
    assign o_dad   = i_mem_result;
    assign o_ddt_w = i_mem_store_data;
    assign o_size  = core_pkg::SIZE_WORD;

    always_ff @(posedge clk) begin
        if (!i_rst_n || !i_hold) begin
            done <= 1'b0;
        end else if (o_mreq && !i_ackd_n) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_mreq && !i_ackd_n) begin
            load_q <= i_ddt_r;
        end
    end

    always_comb begin
        if (!i_mem_load) begin
            wb_value = i_mem_result;
        end else if (done) begin
            wb_value = load_q;
        end else begin
            wb_value = i_ddt_r;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_wb_en <= 1'b0;
            o_wb_rd <= 5'd0;
        end else if (!i_hold) begin
            o_wb_en <= i_mem_wb_en;
            o_wb_rd <= i_mem_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_hold) begin
            o_wb_data <= wb_value;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core (
    input  wire                       clk,
    input  wire                       i_rst_n,
    output logic [core_pkg::XLEN-1:0] o_iad,
    input  wire [core_pkg::XLEN-1:0]  i_idt,
    input  wire                       i_acki_n,
    output logic [core_pkg::XLEN-1:0] o_dad,
    output logic [core_pkg::XLEN-1:0] o_ddt_w,
    input  wire [core_pkg::XLEN-1:0]  i_ddt_r,
    output logic                      o_mreq,
    output logic                      o_write,
    output logic [1:0]                o_size,
    input  wire                       i_ackd_n
);

    // IF/ID
    logic [core_pkg::XLEN-1:0] if_pc;
    logic [core_pkg::XLEN-1:0] if_instr;

    // ID and register file
    logic [4:0]                rs1;
    logic [4:0]                rs2;
    logic [core_pkg::XLEN-1:0] rs1_data;
    logic [core_pkg::XLEN-1:0] rs2_data;

    // ID/EX
    logic [core_pkg::XLEN-1:0] ex_pc;
    logic [core_pkg::XLEN-1:0] ex_a;
    logic [core_pkg::XLEN-1:0] ex_b;
    logic [core_pkg::XLEN-1:0] ex_imm;
    logic [4:0]                ex_rs1;
    logic [4:0]                ex_rs2;
    logic [4:0]                ex_rd;
    core_pkg::alu_op_e         ex_alu_op;
    logic                      ex_use_imm;
    logic                      ex_load;
    logic                      ex_store;
    logic                      ex_branch;
    logic                      ex_bne;
    logic                      ex_jal;
    logic                      ex_wb_en;

    // EX and EX/MEM
    logic                      taken;
    logic [core_pkg::XLEN-1:0] target;
    logic [core_pkg::XLEN-1:0] mem_result;
    logic [core_pkg::XLEN-1:0] mem_store_data;
    logic [4:0]                mem_rd;
    logic                      mem_load;
    logic                      mem_store;
    logic                      mem_wb_en;

    // MEM/WB
    logic                      wb_en;
    logic [4:0]                wb_rd;
    logic [core_pkg::XLEN-1:0] wb_data;

    // Hazard control
    logic                      hold;
    logic                      stall_id;
    logic                      flush;
    core_pkg::fwd_sel_e        fwd_a;
    core_pkg::fwd_sel_e        fwd_b;

    fetch_stage fetch_stage_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_hold     (hold),
        .i_stall_id (stall_id),
        .i_flush    (flush),
        .i_target   (target),
        .i_idt      (i_idt),
        .o_iad      (o_iad),
        .o_if_pc    (if_pc),
        .o_if_instr (if_instr)
    );

    decode_stage decode_stage_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_hold       (hold),
        .i_stall_id   (stall_id),
        .i_flush      (flush),
        .i_pc         (if_pc),
        .i_instr      (if_instr),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_rs1        (rs1),
        .o_rs2        (rs2),
        .o_ex_pc      (ex_pc),
        .o_ex_a       (ex_a),
        .o_ex_b       (ex_b),
        .o_ex_imm     (ex_imm),
        .o_ex_rs1     (ex_rs1),
        .o_ex_rs2     (ex_rs2),
        .o_ex_rd      (ex_rd),
        .o_ex_alu_op  (ex_alu_op),
        .o_ex_use_imm (ex_use_imm),
        .o_ex_load    (ex_load),
        .o_ex_store   (ex_store),
        .o_ex_branch  (ex_branch),
        .o_ex_bne     (ex_bne),
        .o_ex_jal     (ex_jal),
        .o_ex_wb_en   (ex_wb_en)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_we    (wb_en),
        .i_wa    (wb_rd),
        .i_ra1   (rs1),
        .i_ra2   (rs2),
        .i_wd    (wb_data),
        .o_rd1   (rs1_data),
        .o_rd2   (rs2_data)
    );

    execute_stage execute_stage_inst (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_hold           (hold),
        .i_ex_pc          (ex_pc),
        .i_ex_a           (ex_a),
        .i_ex_b           (ex_b),
        .i_ex_imm         (ex_imm),
        .i_ex_rd          (ex_rd),
        .i_ex_alu_op      (ex_alu_op),
        .i_ex_use_imm     (ex_use_imm),
        .i_ex_load        (ex_load),
        .i_ex_store       (ex_store),
        .i_ex_branch      (ex_branch),
        .i_ex_bne         (ex_bne),
        .i_ex_jal         (ex_jal),
        .i_ex_wb_en       (ex_wb_en),
        .i_fwd_a          (fwd_a),
        .i_fwd_b          (fwd_b),
        .i_mem_result     (mem_result),
        .i_wb_data        (wb_data),
        .o_taken          (taken),
        .o_target         (target),
        .o_mem_result     (mem_result),
        .o_mem_store_data (mem_store_data),
        .o_mem_rd         (mem_rd),
        .o_mem_load       (mem_load),
        .o_mem_store      (mem_store),
        .o_mem_wb_en      (mem_wb_en)
    );

    mem_stage mem_stage_inst (
        .clk              (clk),
        .i_rst_n          (i_rst_n),
        .i_hold           (hold),
        .i_mem_result     (mem_result),
        .i_mem_store_data (mem_store_data),
        .i_mem_rd         (mem_rd),
        .i_mem_load       (mem_load),
        .i_mem_store      (mem_store),
        .i_mem_wb_en      (mem_wb_en),
        .i_ddt_r          (i_ddt_r),
        .i_ackd_n         (i_ackd_n),
        .o_dad            (o_dad),
        .o_ddt_w          (o_ddt_w),
        .o_mreq           (o_mreq),
        .o_write          (o_write),
        .o_size           (o_size),
        .o_wb_en          (wb_en),
        .o_wb_rd          (wb_rd),
        .o_wb_data        (wb_data)
    );

    hazard_ctrl hazard_ctrl_inst (
        .i_acki_n    (i_acki_n),
        .i_ackd_n    (i_ackd_n),
        .i_mreq      (o_mreq),
        .i_id_rs1    (rs1),
        .i_id_rs2    (rs2),
        .i_ex_rs1    (ex_rs1),
        .i_ex_rs2    (ex_rs2),
        .i_ex_rd     (ex_rd),
        .i_ex_load   (ex_load),
        .i_ex_wb_en  (ex_wb_en),
        .i_mem_rd    (mem_rd),
        .i_mem_wb_en (mem_wb_en),
        .i_mem_load  (mem_load),
        .i_wb_rd     (wb_rd),
        .i_wb_en     (wb_en),
        .i_taken     (taken),
        .o_hold      (hold),
        .o_stall_id  (stall_id),
        .o_flush     (flush),
        .o_fwd_a     (fwd_a),
        .o_fwd_b     (fwd_b)
    );

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                       clk,
    input  wire                       i_rst_n,
    input  wire                       i_we,
    input  wire [4:0]                 i_wa,
    input  wire [4:0]                 i_ra1,
    input  wire [4:0]                 i_ra2,
    input  wire [core_pkg::XLEN-1:0]  i_wd,
    output logic [core_pkg::XLEN-1:0] o_rd1,
    output logic [core_pkg::XLEN-1:0] o_rd2
);

    // x0 has no storage
    logic [core_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (i_rst_n && i_we && (i_wa != 5'd0)) begin
            regs[i_wa] <= i_wd;
        end
    end

    // Write-through so ID sees the value retiring in WB
    always_comb begin
        if (i_ra1 == 5'd0) begin
            o_rd1 = '0;
        end else if (i_we && (i_wa == i_ra1)) begin
            o_rd1 = i_wd;
        end else begin
            o_rd1 = regs[i_ra1];
        end
        if (i_ra2 == 5'd0) begin
            o_rd2 = '0;
        end else if (i_we && (i_wa == i_ra2)) begin
            o_rd2 = i_wd;
        end else begin
            o_rd2 = regs[i_ra2];
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/hazard_ctrl.sv
verilog/pipe_core.sv
bench/tb_pipe_core.sv
